// ==== hw/fir_pkg.sv ====
`default_nettype none

package fir_pkg;

    parameter int DATA_W = 32;
    parameter int ADDR_W = 12;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Register map
    parameter addr_t AP_CTRL_ADDR  = 12'h000;
    parameter addr_t LEN_ADDR      = 12'h010;
    parameter addr_t TAP_BASE_ADDR = 12'h020;

    parameter int AP_START_BIT = 0;
    parameter int AP_DONE_BIT  = 1;
    parameter int AP_IDLE_BIT  = 2;

    // Taps must end below 0x100
    parameter int MAX_TAPS = 56;

    typedef struct packed {
        logic  we;
        logic  re;
        addr_t addr;
        data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic  start;
        data_t len;
    } run_ctrl_t;

    typedef struct packed {
        logic busy;
        logic done;
    } run_stat_t;

endpackage

`default_nettype wire

// ==== hw/fir_axil_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module fir_axil_slave (
    input  wire                    axis_clk,
    input  wire                    axis_rst_n,
    input  wire                    awvalid,
    output logic                   awready,
    input  wire fir_pkg::addr_t    awaddr,
    input  wire                    wvalid,
    output logic                   wready,
    input  wire fir_pkg::data_t    wdata,
    input  wire                    arvalid,
    output logic                   arready,
    input  wire fir_pkg::addr_t    araddr,
    output logic                   rvalid,
    input  wire                    rready,
    output fir_pkg::data_t         rdata,
    input  wire fir_pkg::data_t    rd_data,
    output fir_pkg::reg_req_t      req
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD,
        S_WR
    } state_t;

    state_t         state;
    logic           wr_go;
    logic           rd_go;
    fir_pkg::data_t rdata_q;

    // Write wins when both arrive together
    assign wr_go = (state == S_IDLE) & awvalid & wvalid;
    assign rd_go = (state == S_IDLE) & arvalid & ~wr_go;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;
    assign rvalid  = (state == S_RD);
    assign rdata   = rdata_q;

    assign req = '{
        we:    wr_go,
        re:    rd_go,
        addr:  wr_go ? awaddr : araddr,
        wdata: wdata
    };

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (wr_go) begin
                        state <= S_WR;
                    end else if (rd_go) begin
                        state <= S_RD;
                    end
                end
                S_RD: begin
                    if (rready) begin
                        state <= S_IDLE;
                    end
                end
                S_WR:    state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Held for the whole R phase
    always_ff @(posedge axis_clk) begin
        if (rd_go) begin
            rdata_q <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fir_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module fir_regs #(
    parameter int N_TAPS = 11,
    localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1
) (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire fir_pkg::reg_req_t  req,
    output fir_pkg::data_t          rd_data,
    output fir_pkg::run_ctrl_t      ctrl,
    input  wire fir_pkg::run_stat_t stat,
    input  wire [IDX_W-1:0]         tap_idx,
    output fir_pkg::data_t          tap_coef
);

    logic           ap_start;
    logic           ap_done;
    logic           ap_idle;
    logic           locked;
    logic           hit_ctrl;
    logic           hit_len;
    logic           hit_tap;
    fir_pkg::addr_t tap_off;
    logic [IDX_W-1:0] tap_wi;
    fir_pkg::data_t len_q;
    fir_pkg::data_t coef [N_TAPS];

    assign hit_ctrl = (req.addr == fir_pkg::AP_CTRL_ADDR);
    assign hit_len  = (req.addr == fir_pkg::LEN_ADDR);
    assign tap_off  = req.addr - fir_pkg::TAP_BASE_ADDR;
    assign hit_tap  = (req.addr >= fir_pkg::TAP_BASE_ADDR) &&
                      (tap_off < fir_pkg::addr_t'(4 * N_TAPS));
    assign tap_wi   = tap_off[IDX_W+1:2];
    assign locked   = ~ap_idle | stat.busy;

    assign ctrl     = '{start: ap_start, len: len_q};
    assign tap_coef = coef[tap_idx];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            ap_start <= 1'b0;
            if (req.we && hit_ctrl && req.wdata[fir_pkg::AP_START_BIT] && !locked) begin
                ap_start <= 1'b1;
                ap_idle  <= 1'b0;
            end
            // Done is read-to-clear
            if (req.re && hit_ctrl) begin
                ap_done <= 1'b0;
            end
            if (stat.done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            len_q <= '0;
            for (int i = 0; i < N_TAPS; i++) begin
                coef[i] <= '0;
            end
        end else if (req.we && !locked) begin
            if (hit_len) begin
                len_q <= req.wdata;
            end
            for (int i = 0; i < N_TAPS; i++) begin
                if (hit_tap && tap_wi == IDX_W'(i)) begin
                    coef[i] <= req.wdata;
                end
            end
        end
    end

    always_comb begin
        rd_data = '0;
        if (hit_ctrl) begin
            rd_data[fir_pkg::AP_START_BIT] = ap_start;
            rd_data[fir_pkg::AP_DONE_BIT]  = ap_done;
            rd_data[fir_pkg::AP_IDLE_BIT]  = ap_idle;
        end else if (hit_len) begin
            rd_data = len_q;
        end else if (hit_tap) begin
            for (int i = 0; i < N_TAPS; i++) begin
                if (tap_wi == IDX_W'(i)) begin
                    rd_data = coef[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fir_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module fir_engine #(
    parameter int N_TAPS = 11,
    localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1
) (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire fir_pkg::run_ctrl_t ctrl,
    output fir_pkg::run_stat_t      stat,
    output logic [IDX_W-1:0]        tap_idx,
    input  wire fir_pkg::data_t     tap_coef,
    input  wire                     ss_tvalid,
    input  wire fir_pkg::data_t     ss_tdata,
    output logic                    ss_tready,
    output logic                    sm_tvalid,
    output fir_pkg::data_t          sm_tdata,
    output logic                    sm_tlast,
    input  wire                     sm_tready
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_CLEAR,
        E_ACCEPT,
        E_ACC,
        E_OUT
    } state_t;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_TAPS - 1);

    state_t         state;
    fir_pkg::data_t out_cnt;
    fir_pkg::data_t len_q;
    fir_pkg::data_t acc;
    fir_pkg::data_t prod;
    fir_pkg::data_t shift_in;
    logic           shift_en;
    logic           take;
    logic           give;
    fir_pkg::data_t hist [N_TAPS];

    assign take = (state == E_ACCEPT) & ss_tvalid;
    assign give = (state == E_OUT) & sm_tready;

    assign ss_tready = (state == E_ACCEPT);
    assign sm_tvalid = (state == E_OUT);
    assign sm_tdata  = acc;
    assign sm_tlast  = (state == E_OUT) && ((out_cnt + 1'b1) == len_q);

    assign stat = '{busy: (state != E_IDLE), done: give & sm_tlast};

    // Low 32 bits of the product
    assign prod = tap_coef * hist[tap_idx];

    // Zeros flush the history while clearing
    assign shift_en = (state == E_CLEAR) | take;
    assign shift_in = take ? ss_tdata : '0;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= E_IDLE;
            tap_idx <= '0;
            out_cnt <= '0;
            len_q   <= '0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (ctrl.start) begin
                        state   <= E_CLEAR;
                        tap_idx <= '0;
                        out_cnt <= '0;
                        len_q   <= ctrl.len;
                    end
                end
                E_CLEAR: begin
                    if (tap_idx == LAST_IDX) begin
                        tap_idx <= '0;
                        state   <= E_ACCEPT;
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                E_ACCEPT: begin
                    if (ss_tvalid) begin
                        state <= E_ACC;
                    end
                end
                E_ACC: begin
                    if (tap_idx == LAST_IDX) begin
                        tap_idx <= '0;
                        state   <= E_OUT;
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                E_OUT: begin
                    if (sm_tready) begin
                        out_cnt <= out_cnt + 1'b1;
                        state   <= sm_tlast ? E_IDLE : E_ACCEPT;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (shift_en) begin
            hist[0] <= shift_in;
            for (int i = 1; i < N_TAPS; i++) begin
                hist[i] <= hist[i-1];
            end
        end
        if (take) begin
            acc <= '0;
        end else if (state == E_ACC) begin
            acc <= acc + prod;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fir_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fir_top #(
    parameter int N_TAPS = 11
) (
    input  wire                 axis_clk,
    input  wire                 axis_rst_n,
    input  wire                 awvalid,
    output logic                awready,
    input  wire fir_pkg::addr_t awaddr,
    input  wire                 wvalid,
    output logic                wready,
    input  wire fir_pkg::data_t wdata,
    input  wire                 arvalid,
    output logic                arready,
    input  wire fir_pkg::addr_t araddr,
    output logic                rvalid,
    input  wire                 rready,
    output fir_pkg::data_t      rdata,
    input  wire                 ss_tvalid,
    input  wire fir_pkg::data_t ss_tdata,
    output logic                ss_tready,
    output logic                sm_tvalid,
    output fir_pkg::data_t      sm_tdata,
    output logic                sm_tlast,
    input  wire                 sm_tready
);

    localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1;

    fir_pkg::reg_req_t  req;
    fir_pkg::data_t     rd_data;
    fir_pkg::run_ctrl_t ctrl;
    fir_pkg::run_stat_t stat;
    logic [IDX_W-1:0]   tap_idx;
    fir_pkg::data_t     tap_coef;

    fir_axil_slave axil_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rd_data    (rd_data),
        .req        (req)
    );

    fir_regs #(
        .N_TAPS (N_TAPS)
    ) regs_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .req        (req),
        .rd_data    (rd_data),
        .ctrl       (ctrl),
        .stat       (stat),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef)
    );

    fir_engine #(
        .N_TAPS (N_TAPS)
    ) engine_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ctrl       (ctrl),
        .stat       (stat),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

endmodule

`default_nettype wire

// ==== bench/fir_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fir_tb;

    localparam int N_TAPS  = 11;
    localparam int RUN_LEN = 16;
    // Two runs of 16 samples at about 20 cycles each, stretched by stalls, plus setup
    localparam int MAX_CYCLES = 20000;

    logic           axis_clk;
    logic           axis_rst_n;
    logic           awvalid;
    logic           awready;
    fir_pkg::addr_t awaddr;
    logic           wvalid;
    logic           wready;
    fir_pkg::data_t wdata;
    logic           arvalid;
    logic           arready;
    fir_pkg::addr_t araddr;
    logic           rvalid;
    logic           rready;
    fir_pkg::data_t rdata;
    logic           ss_tvalid;
    fir_pkg::data_t ss_tdata;
    logic           ss_tready;
    logic           sm_tvalid;
    fir_pkg::data_t sm_tdata;
    logic           sm_tlast;
    logic           sm_tready;

    logic [31:0]    lfsr = 32'hf425;
    fir_pkg::data_t taps [N_TAPS];
    fir_pkg::data_t src_q [$];
    fir_pkg::data_t exp_q [$];
    string          cur_test = "idle";
    logic           stall_en = 1'b0;
    int             outs_seen = 0;
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;

    fir_top #(
        .N_TAPS (N_TAPS)
    ) dut_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timed out after %0d cycles with %0d outputs seen", cycles, outs_seen);
            $display("Test failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic fir_pkg::data_t rand_bits(input int n);
        fir_pkg::data_t r;
        logic           fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Output n of the filter with zero history before x[0]
    function automatic fir_pkg::data_t fir_model(input fir_pkg::data_t h [N_TAPS],
                                                 input fir_pkg::data_t x [RUN_LEN],
                                                 input int n);
        fir_pkg::data_t y;
        y = '0;
        for (int k = 0; k < N_TAPS; k++) begin
            if (n - k >= 0) begin
                y = y + h[k] * x[n-k];
            end
        end
        return y;
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("%s (at %0t)", msg, $time);
    endtask

    task automatic check_value(input string name, input fir_pkg::data_t expected,
                               input fir_pkg::data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic axil_write(input fir_pkg::addr_t addr, input fir_pkg::data_t data);
        @(posedge axis_clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge axis_clk);
        while (!(awready && wready)) @(negedge axis_clk);
        @(posedge axis_clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_read(input fir_pkg::addr_t addr, output fir_pkg::data_t data);
        @(posedge axis_clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        #2;
        arvalid = 1'b0;
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        data = rdata;
        @(posedge axis_clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic start_run(input string name, input logic stalls);
        fir_pkg::data_t x [RUN_LEN];
        @(negedge axis_clk);
        for (int i = 0; i < RUN_LEN; i++) begin
            x[i] = rand_bits(32);
            src_q.push_back(x[i]);
        end
        for (int i = 0; i < RUN_LEN; i++) begin
            exp_q.push_back(fir_model(taps, x, i));
        end
        cur_test  = name;
        outs_seen = 0;
        stall_en  = stalls;
        axil_write(fir_pkg::AP_CTRL_ADDR, 32'h1);
    endtask

    task automatic wait_outputs();
        while (outs_seen < RUN_LEN) @(posedge axis_clk);
        repeat (2) @(posedge axis_clk);
    endtask

    // Upstream source and downstream sink
    initial begin : stream_driver
        logic ss_fire;
        wait (axis_rst_n === 1'b1);
        forever begin
            @(negedge axis_clk);
            ss_fire = ss_tvalid & ss_tready;
            @(posedge axis_clk);
            #2;
            if (!ss_tvalid || ss_fire) begin
                ss_tvalid = 1'b0;
                if (src_q.size() > 0 && (!stall_en || rand_bits(2) != 0)) begin
                    ss_tdata  = src_q.pop_front();
                    ss_tvalid = 1'b1;
                end
            end
            sm_tready = !stall_en || (rand_bits(2) != 0);
        end
    end

    initial begin : compare_outputs
        fir_pkg::data_t expected;
        fir_pkg::data_t held_data;
        logic           held_valid;
        held_valid = 1'b0;
        held_data  = '0;
        wait (axis_rst_n === 1'b1);
        forever begin
            @(negedge axis_clk);
            if (held_valid) begin
                checks++;
                if (sm_tvalid !== 1'b1) begin
                    report_failure("sm_tvalid dropped while the output was stalled");
                end else if (sm_tdata !== held_data) begin
                    report_failure("sm_tdata changed while the output was stalled");
                end
            end
            if (sm_tvalid && sm_tready) begin
                if (exp_q.size() == 0) begin
                    report_failure("output transfer with no expected value pending");
                end else begin
                    expected = exp_q.pop_front();
                    check_value(cur_test, expected, sm_tdata);
                    check_value({cur_test, "_tlast"},
                                fir_pkg::data_t'(outs_seen == RUN_LEN - 1),
                                fir_pkg::data_t'(sm_tlast));
                end
                outs_seen++;
                held_valid = 1'b0;
            end else begin
                held_valid = (sm_tvalid === 1'b1);
                held_data  = sm_tdata;
            end
        end
    end

    initial begin : main
        fir_pkg::data_t v;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (10) @(posedge axis_clk);
        #2;
        axis_rst_n = 1'b1;

        @(negedge axis_clk);
        if (awready !== 1'b0) report_failure("awready is not low after reset");
        if (wready !== 1'b0) report_failure("wready is not low after reset");
        if (arready !== 1'b0) report_failure("arready is not low after reset");
        if (rvalid !== 1'b0) report_failure("rvalid is not low after reset");
        if (ss_tready !== 1'b0) report_failure("ss_tready is not low after reset");
        if (sm_tvalid !== 1'b0) report_failure("sm_tvalid is not low after reset");
        if (sm_tlast !== 1'b0) report_failure("sm_tlast is not low after reset");
        axil_read(fir_pkg::AP_CTRL_ADDR, v);
        check_value("reset_ctrl", 32'h4, v);

        for (int i = 0; i < N_TAPS; i++) begin
            taps[i] = rand_bits(32);
            axil_write(fir_pkg::TAP_BASE_ADDR + fir_pkg::addr_t'(4 * i), taps[i]);
        end
        axil_write(fir_pkg::LEN_ADDR, RUN_LEN);
        for (int i = 0; i < N_TAPS; i++) begin
            axil_read(fir_pkg::TAP_BASE_ADDR + fir_pkg::addr_t'(4 * i), v);
            check_value("tap_readback", taps[i], v);
        end
        axil_read(fir_pkg::LEN_ADDR, v);
        check_value("len_readback", RUN_LEN, v);
        axil_read(12'h004, v);
        check_value("unmapped_read", 32'h0, v);
        axil_read(12'h0f0, v);
        check_value("unmapped_read", 32'h0, v);

        start_run("run_plain", 1'b0);
        wait_outputs();
        axil_read(fir_pkg::AP_CTRL_ADDR, v);
        check_value("done_set", 32'h6, v);
        axil_read(fir_pkg::AP_CTRL_ADDR, v);
        check_value("done_cleared", 32'h4, v);

        // Fresh samples, stalls on both sides and a tap write while busy
        start_run("run_stall", 1'b1);
        axil_read(fir_pkg::AP_CTRL_ADDR, v);
        check_value("busy_idle", 32'h0, fir_pkg::data_t'(v[fir_pkg::AP_IDLE_BIT]));
        axil_write(fir_pkg::TAP_BASE_ADDR, ~taps[0]);
        axil_read(fir_pkg::TAP_BASE_ADDR, v);
        check_value("busy_tap_write", taps[0], v);
        wait_outputs();
        stall_en = 1'b0;
        axil_read(fir_pkg::AP_CTRL_ADDR, v);
        check_value("done_set_stall", 32'h6, v);
        if (exp_q.size() != 0) report_failure("expected outputs were never produced");

        repeat (5) @(posedge axis_clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/fir_pkg.sv
hw/fir_axil_slave.sv
hw/fir_regs.sv
hw/fir_engine.sv
hw/fir_top.sv
bench/fir_tb.sv

// ==== Makefile ====
TOP       ?= fir_tb
SRCS      ?= src.f
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(SRCS) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(SRCS) --top-module $(TOP)
	$(VERILATOR) --lint-only -f $(SRCS) --top-module fir_top

clean:
	rm -rf $(OBJ_DIR)
